// ==== list.f ====
source/isa_pkg.sv
source/bus_pkg.sv
source/fetch_unit.sv
source/prefetch_buffer.sv
source/exec_unit.sv
source/mini_core.sv
sim/tb_mini_core.sv

// ==== Makefile ====
# Verilator build and run for the mini core testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=./build

VERILATOR ?= verilator
TOP       ?= tb_mini_core
FILELIST  ?= list.f
BUILD_DIR ?= ./obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing
PASS_MSG  ?= All checks passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/program_vectors.txt ====
// Line 1: boot address, instruction count
// Then one line per instruction: word, expected rd, wdata, we, illegal
00001000 00000010
// Immediates and a dependent chain
00500093 00000001 00000005 00000001 00000000
FFD00113 00000002 FFFFFFFD 00000001 00000000
002081B3 00000003 00000002 00000001 00000000
40208233 00000004 00000008 00000001 00000000
123452B7 00000005 12345000 00000001 00000000
6782E313 00000006 12345678 00000001 00000000
FFF34393 00000007 EDCBA987 00000001 00000000
00737433 00000008 00000000 00000001 00000000
// Write to x0, then a read of x0
00708013 00000000 0000000C 00000000 00000000
001004B3 00000009 00000005 00000001 00000000
// Unsupported shift and an all-zero word
00209513 0000000A 00000000 00000000 00000001
00000000 00000000 00000000 00000000 00000001
// x10 still unwritten after the illegal shift
001505B3 0000000B 00000005 00000001 00000000
0020E533 0000000A FFFFFFFD 00000001 00000000
00354633 0000000C FFFFFFFF 00000001 00000000
0F067693 0000000D 000000F0 00000001 00000000

// ==== sim/tb_mini_core.sv ====
//////////////////////////////////////////////////
// Mini core testbench
// Instruction memory model with random bus delays,
// retire checker against the program vectors
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_mini_core import isa_pkg::*, bus_pkg::*;;

  localparam string       VEC_FILE    = "sim/program_vectors.txt";
  localparam logic [31:0] SEED        = 32'hc9cee213;
  localparam int          RUN_TIMEOUT = 2000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        fetch_enable;
  addr_t       boot_addr;
  instr_req_t  instr_req;
  instr_resp_t instr_resp = '0;
  logic        retire_valid;
  logic        retire_ready = 1'b0;
  retire_t     retire;

  // Vector file image and run state
  logic [31:0] vec_mem [0:255];
  addr_t       boot_file;
  int          prog_len;
  bit          random_mode = 1'b0;
  retire_t     ret_q [$];
  addr_t       pend_addr [$];
  int          pend_due [$];
  int          gnt_wait;
  int          cycle;
  int          peak;
  int          n_checks = 0;
  int          n_errors = 0;
  int          cat_checks [4];
  int          cat_errs [4];

  mini_core u_mini_core (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .fetch_enable_i (fetch_enable),
    .boot_addr_i    (boot_addr),
    .instr_req_o    (instr_req),
    .instr_resp_i   (instr_resp),
    .retire_valid_o (retire_valid),
    .retire_ready_i (retire_ready),
    .retire_o       (retire)
  );

  // 8 ns clock
  initial begin
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Instruction memory model
  //////////////////////////////////////////////////

  // Program words inside the image and an address-based fill elsewhere
  function automatic word_t mem_word(input addr_t addr);
    addr_t offset;
    offset = addr - boot_file;
    if (addr >= boot_file && offset[1:0] == 2'b00 && (offset >> 2) < addr_t'(prog_len)) begin
      return vec_mem[2 + 5 * int'(offset >> 2)];
    end
    return addr ^ 32'h5a5a_c3c3;
  endfunction

  always @(posedge clk) begin
    logic  gnt_n;
    logic  rvalid_n;
    word_t rdata_n;
    int    due;
    gnt_n    = 1'b0;
    rvalid_n = 1'b0;
    rdata_n  = '0;
    if (!rst_n) begin
      pend_addr.delete();
      pend_due.delete();
      gnt_wait = 0;
      cycle    = 0;
      peak     = 0;
    end else begin
      cycle++;
      if (instr_req.req && instr_resp.gnt) begin
        // Data due 1 or 2 cycles after the grant and never out of order
        due = cycle + (random_mode ? int'($urandom_range(1, 0)) : 0);
        if (pend_due.size() > 0 && due <= pend_due[$]) begin
          due = pend_due[$] + 1;
        end
        pend_addr.push_back(instr_req.addr);
        pend_due.push_back(due);
        gnt_wait = random_mode ? int'($urandom_range(3, 0)) : 0;
        // A zero wait grants back to back while req stays high
        gnt_n = (gnt_wait == 0);
      end else if (instr_req.req) begin
        if (gnt_wait > 0) begin
          gnt_wait--;
        end
        gnt_n = (gnt_wait == 0);
      end
      if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
        rvalid_n = 1'b1;
        rdata_n  = mem_word(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      // Granted and not yet seen by fetch as rvalid
      if (pend_addr.size() + int'(rvalid_n) > peak) begin
        peak = pend_addr.size() + int'(rvalid_n);
      end
    end
    instr_resp.gnt    <= gnt_n;
    instr_resp.rvalid <= rvalid_n;
    instr_resp.rdata  <= rdata_n;
  end

  //////////////////////////////////////////////////
  // Retire side
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (random_mode) begin
      retire_ready <= ($urandom_range(1, 0) == 1);
    end else begin
      retire_ready <= 1'b1;
    end
  end

  // Records taken in order of consumption
  always @(posedge clk) begin
    if (!rst_n) begin
      ret_q.delete();
    end else if (retire_valid && retire_ready) begin
      ret_q.push_back(retire);
    end
  end

  //////////////////////////////////////////////////
  // Checks and test steps
  //////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // 8 cycles of reset with fetch held off
  task automatic apply_reset();
    @(posedge clk);
    rst_n        <= 1'b0;
    fetch_enable <= 1'b0;
    boot_addr    <= boot_file;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic check_reset_state();
    int i;
    int errs0;
    errs0 = n_errors;
    apply_reset();
    for (i = 0; i < 20; i++) begin
      @(posedge clk);
      check_value("req after reset", 32'(instr_req.req), 32'd0);
      check_value("retire_valid after reset", 32'(retire_valid), 32'd0);
    end
    $display("Test reset state: 40 checks, %0d errors", n_errors - errs0);
  endtask

  // Reset, enable fetch, wait for the whole program to retire
  task automatic run_program(input bit rand_mode);
    int wait_cycles;
    random_mode = rand_mode;
    apply_reset();
    @(posedge clk);
    fetch_enable <= 1'b1;
    wait_cycles = 0;
    while (ret_q.size() < prog_len && wait_cycles < RUN_TIMEOUT) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (ret_q.size() < prog_len) begin
      n_errors++;
      $display("Timeout: only %0d of %0d instructions retired after %0d cycles",
               ret_q.size(), prog_len, RUN_TIMEOUT);
    end
  endtask

  // Category 0 pc, 1 ALU write, 2 write to x0, 3 illegal
  task automatic check_program();
    int i;
    int n;
    int base;
    int cat;
    int errs0;
    n = (ret_q.size() < prog_len) ? ret_q.size() : prog_len;
    for (i = 0; i < 4; i++) begin
      cat_checks[i] = 0;
      cat_errs[i]   = 0;
    end
    for (i = 0; i < n; i++) begin
      base  = 2 + 5 * i;
      cat   = vec_mem[base+4][0] ? 3 : ((vec_mem[base+1] == 32'd0) ? 2 : 1);
      errs0 = n_errors;
      check_value($sformatf("pc of retire %0d", i), ret_q[i].pc,
                  boot_file + 32'(i) * INSTR_BYTES);
      cat_checks[0]++;
      cat_errs[0] += n_errors - errs0;
      errs0 = n_errors;
      check_value($sformatf("rd of retire %0d", i), 32'(ret_q[i].rd), vec_mem[base+1]);
      check_value($sformatf("wdata of retire %0d", i), ret_q[i].wdata, vec_mem[base+2]);
      check_value($sformatf("we of retire %0d", i), 32'(ret_q[i].we), vec_mem[base+3]);
      check_value($sformatf("illegal of retire %0d", i), 32'(ret_q[i].illegal),
                  vec_mem[base+4]);
      cat_checks[cat] += 4;
      cat_errs[cat]   += n_errors - errs0;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int errs0;
    $readmemh(VEC_FILE, vec_mem);
    boot_file = vec_mem[0];
    prog_len  = int'(vec_mem[1]);
    void'($urandom(SEED));
    rst_n        <= 1'b0;
    fetch_enable <= 1'b0;
    boot_addr    <= boot_file;

    check_reset_state();

    // Full-speed run with ready always high
    run_program(1'b0);
    check_program();
    $display("Test program order: %0d checks, %0d errors", cat_checks[0], cat_errs[0]);
    $display("Test ALU results: %0d checks, %0d errors", cat_checks[1], cat_errs[1]);
    $display("Test register zero: %0d checks, %0d errors", cat_checks[2], cat_errs[2]);
    $display("Test illegal encodings: %0d checks, %0d errors", cat_checks[3], cat_errs[3]);

    // Same program under random stalls on both sides
    errs0 = n_errors;
    run_program(1'b1);
    check_program();
    check_value("peak outstanding within limit", 32'(peak <= int'(MAX_OUTSTANDING)), 32'd1);
    $display("Test back-pressure: peak outstanding %0d, %0d errors", peak, n_errors - errs0);

    $display("Done: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== source/mini_core.sv ====
//////////////////////////////////////////////////
// Mini core top level
// Fetch, prefetch buffer and execute in a row
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mini_core import isa_pkg::*, bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        fetch_enable_i,
  input  addr_t       boot_addr_i,
  output instr_req_t  instr_req_o,
  input  instr_resp_t instr_resp_i,
  output logic        retire_valid_o,
  input  logic        retire_ready_i,
  output retire_t     retire_o
);

  // Fetch to buffer
  logic         push_valid;
  fetch_entry_t push_entry;
  slot_cnt_t    free_slots;

  // Buffer to execute
  logic         buf_valid;
  logic         buf_ready;
  fetch_entry_t buf_entry;

  fetch_unit u_fetch_unit (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_resp_i   (instr_resp_i),
    .free_slots_i   (free_slots),
    .push_valid_o   (push_valid),
    .push_entry_o   (push_entry)
  );

  prefetch_buffer u_prefetch_buffer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_valid_i (push_valid),
    .push_entry_i (push_entry),
    .free_slots_o (free_slots),
    .pop_valid_o  (buf_valid),
    .pop_ready_i  (buf_ready),
    .pop_entry_o  (buf_entry)
  );

  exec_unit u_exec_unit (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .entry_valid_i  (buf_valid),
    .entry_ready_o  (buf_ready),
    .entry_i        (buf_entry),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_o       (retire_o)
  );

endmodule

// ==== source/exec_unit.sv ====
//////////////////////////////////////////////////
// Execute unit
// RV32I subset decode, register file, ALU and the
// retire register with back-pressure
//////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_unit import isa_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         entry_valid_i,
  output logic         entry_ready_o,
  input  fetch_entry_t entry_i,
  output logic         retire_valid_o,
  input  logic         retire_ready_i,
  output retire_t      retire_o
);

  word_t                instr;
  logic [6:0]           opcode_raw;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  rf_addr_t             rd;
  rf_addr_t             rs1;
  rf_addr_t             rs2;
  word_t                imm;
  logic                 use_imm;
  logic                 legal;
  alu_op_e              alu_op;
  word_t                rf_q [RF_DEPTH];
  logic [RF_DEPTH-1:0]  rf_valid_q;
  word_t                op_a;
  word_t                op_b;
  word_t                alu_result;
  logic                 rd_we;
  logic                 accept;
  retire_t              retire_d;
  retire_t              retire_q;
  logic                 retire_valid_q;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign instr      = entry_i.instr;
  assign opcode_raw = instr[6:0];
  assign rd         = instr[11:7];
  assign funct3     = instr[14:12];
  assign rs1        = instr[19:15];
  assign rs2        = instr[24:20];
  assign funct7     = instr[31:25];

  always_comb begin
    alu_op  = ALU_ADD;
    use_imm = 1'b0;
    legal   = 1'b1;
    // I-type immediate unless LUI
    imm     = {{20{instr[31]}}, instr[31:20]};
    case (opcode_e'(opcode_raw))
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          F3_ADD_SUB: alu_op = ALU_ADD;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          // Shifts and compares not supported
          default:    legal = 1'b0;
        endcase
      end
      OPC_OP: begin
        case ({funct7, funct3})
          {F7_BASE, F3_ADD_SUB}: alu_op = ALU_ADD;
          {F7_SUB, F3_ADD_SUB}:  alu_op = ALU_SUB;
          {F7_BASE, F3_XOR}:     alu_op = ALU_XOR;
          {F7_BASE, F3_OR}:      alu_op = ALU_OR;
          {F7_BASE, F3_AND}:     alu_op = ALU_AND;
          default:               legal = 1'b0;
        endcase
      end
      OPC_LUI: begin
        use_imm = 1'b1;
        alu_op  = ALU_PASS_B;
        imm     = {instr[31:12], 12'b0};
      end
      default: legal = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Register file and ALU
  //////////////////////////////////////////////////

  // Unwritten registers read zero, x0 is never written
  assign op_a = rf_valid_q[rs1] ? rf_q[rs1] : '0;
  assign op_b = use_imm ? imm : (rf_valid_q[rs2] ? rf_q[rs2] : '0);

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      default:    alu_result = op_b;
    endcase
  end

  assign rd_we = legal && (rd != '0);

  // Written at accept, so the next instruction sees it
  always_ff @(posedge clk_i) begin
    if (accept && rd_we) begin
      rf_q[rd] <= alu_result;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rf_valid_q <= '0;
    end else if (accept && rd_we) begin
      rf_valid_q[rd] <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Retire register
  //////////////////////////////////////////////////

  // Free slot or record leaving this cycle
  assign entry_ready_o = !retire_valid_q || retire_ready_i;
  assign accept        = entry_valid_i && entry_ready_o;

  always_comb begin
    retire_d.pc      = entry_i.pc;
    retire_d.rd      = rd;
    retire_d.wdata   = legal ? alu_result : '0;
    retire_d.we      = rd_we;
    retire_d.illegal = !legal;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      retire_valid_q <= 1'b0;
    end else if (accept) begin
      retire_valid_q <= 1'b1;
    end else if (retire_ready_i) begin
      retire_valid_q <= 1'b0;
    end
  end

  // Held stable while ready is low
  always_ff @(posedge clk_i) begin
    if (accept) begin
      retire_q <= retire_d;
    end
  end

  assign retire_valid_o = retire_valid_q;
  assign retire_o       = retire_q;

endmodule

// ==== source/prefetch_buffer.sv ====
//////////////////////////////////////////////////
// Prefetch buffer
// Circular FIFO of fetched entries between fetch
// and execute, head read straight from storage
//////////////////////////////////////////////////

`timescale 1ns/1ps

module prefetch_buffer import isa_pkg::*, bus_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         push_valid_i,
  input  fetch_entry_t push_entry_i,
  output slot_cnt_t    free_slots_o,
  output logic         pop_valid_o,
  input  logic         pop_ready_i,
  output fetch_entry_t pop_entry_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  fetch_entry_t     mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop;

  assign pop = pop_valid_o && pop_ready_i;

  //////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////

  // Fetch never pushes without room
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_valid_i) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      // Push and pop together leave the count
      case ({push_valid_i, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_valid_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  // Head visible the cycle after its push
  assign pop_valid_o  = (count_q != '0);
  assign pop_entry_o  = mem_q[rd_ptr_q];
  assign free_slots_o = slot_cnt_t'(DEPTH) - slot_cnt_t'(count_q);

endmodule

// ==== source/fetch_unit.sv ====
//////////////////////////////////////////////////
// Fetch unit
// Sequential instruction requests, limited by the
// buffer room left after the words still in flight
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_unit import isa_pkg::*, bus_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         fetch_enable_i,
  input  addr_t        boot_addr_i,
  output instr_req_t   instr_req_o,
  input  instr_resp_t  instr_resp_i,
  input  slot_cnt_t    free_slots_i,
  output logic         push_valid_o,
  output fetch_entry_t push_entry_o
);

  typedef enum logic {
    FETCH_IDLE,
    FETCH_RUN
  } fetch_state_e;

  fetch_state_e           state_q;
  addr_t                  addr_q;
  outst_cnt_t             in_flight_q;
  addr_t                  pc_q [MAX_OUTSTANDING];
  logic [OUTST_PTR_W-1:0] wr_ptr_q;
  logic [OUTST_PTR_W-1:0] rd_ptr_q;
  logic                   room;
  logic                   gnt_hs;
  logic                   rvalid;

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  // Room only shrinks on gnt, so req holds until granted
  assign room = (free_slots_i > slot_cnt_t'(in_flight_q)) &&
                (in_flight_q < outst_cnt_t'(MAX_OUTSTANDING));

  assign instr_req_o.req  = (state_q == FETCH_RUN) && room;
  assign instr_req_o.addr = addr_q;

  assign gnt_hs = instr_req_o.req && instr_resp_i.gnt;
  assign rvalid = instr_resp_i.rvalid;

  // Sticky enable, nothing ever redirects fetch
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= FETCH_IDLE;
    end else if (state_q == FETCH_IDLE && fetch_enable_i) begin
      state_q <= FETCH_RUN;
    end
  end

  // Boot address tracked while idle
  always_ff @(posedge clk_i) begin
    if (state_q == FETCH_IDLE) begin
      addr_q <= boot_addr_i;
    end else if (gnt_hs) begin
      addr_q <= addr_q + addr_t'(INSTR_BYTES);
    end
  end

  //////////////////////////////////////////////////
  // Outstanding PCs
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_flight_q <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
    end else begin
      // Up on gnt, down on rvalid
      in_flight_q <= in_flight_q + outst_cnt_t'(gnt_hs) - outst_cnt_t'(rvalid);
      if (gnt_hs) begin
        wr_ptr_q <= wr_ptr_q + OUTST_PTR_W'(1);
      end
      if (rvalid) begin
        rd_ptr_q <= rd_ptr_q + OUTST_PTR_W'(1);
      end
    end
  end

  // PC of each granted request
  always_ff @(posedge clk_i) begin
    if (gnt_hs) begin
      pc_q[wr_ptr_q] <= addr_q;
    end
  end

  // In-order data pairs with the oldest PC
  assign push_valid_o       = rvalid;
  assign push_entry_o.pc    = pc_q[rd_ptr_q];
  assign push_entry_o.instr = instr_resp_i.rdata;

endmodule

// ==== source/bus_pkg.sv ====
//////////////////////////////////////////////////
// Instruction bus definitions
// Request and response payloads of the req/gnt/rvalid
// bus and the flow control limits on the fetch side
//////////////////////////////////////////////////

package bus_pkg;

  import isa_pkg::*;

  // Driven by fetch, 33 bits
  typedef struct packed {
    logic  req;
    addr_t addr;
  } instr_req_t;

  // Driven by memory, 34 bits
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } instr_resp_t;

  // Granted requests still waiting for rvalid
  localparam int unsigned MAX_OUTSTANDING = 2;
  localparam int unsigned OUTST_CNT_W     = $clog2(MAX_OUTSTANDING + 1);
  localparam int unsigned OUTST_PTR_W     = $clog2(MAX_OUTSTANDING);

  typedef logic [OUTST_CNT_W-1:0] outst_cnt_t;

  // Free slot count reported by the buffer
  // wide enough for any practical buffer depth
  localparam int unsigned SLOT_CNT_W = 8;

  typedef logic [SLOT_CNT_W-1:0] slot_cnt_t;

endpackage

// ==== source/isa_pkg.sv ====
//////////////////////////////////////////////////
// ISA definitions
// Widths, register types, opcode and ALU encodings
// and the records passed along the pipeline
//////////////////////////////////////////////////

package isa_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int unsigned XLEN        = 32;
  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned RF_ADDR_W   = 5;
  localparam int unsigned RF_DEPTH    = 32;
  // Byte step between sequential instructions
  localparam int unsigned INSTR_BYTES = 4;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // funct3 values of the supported ops
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 for register-register ops
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  //////////////////////////////////////////////////
  // Pipeline records
  //////////////////////////////////////////////////

  // Fetched word with its PC, 64 bits
  typedef struct packed {
    addr_t pc;
    word_t instr;
  } fetch_entry_t;

  // One retired instruction, 71 bits
  typedef struct packed {
    addr_t    pc;
    rf_addr_t rd;
    word_t    wdata;
    logic     we;
    logic     illegal;
  } retire_t;

endpackage
